// File: compile.f
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/exec_pipe.sv
logic/rv_pipeline.sv
dv/rv_pipeline_checker.sv
dv/rv_pipeline_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module rv_pipeline_tb -f compile.f \
  --Mdir obj_dir -o rv_pipeline_sim

./obj_dir/rv_pipeline_sim | tee sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

// File: dv/rv_pipeline_tb.sv
`timescale 1ns/100ps

module rv_pipeline_tb import rv_pkg::*; ();

  localparam int prog_len = 200;
  localparam int idx_w = $clog2(prog_len);
  localparam int reset_cycles = 8;
  // reset, pipeline fill, up to three cycles per instruction, margin
  localparam int max_cycles = reset_cycles + 4 + 3 * prog_len + 20;

  logic            clk;
  logic            rst;
  logic [31:0]     insn_in;
  logic [xlen-1:0] fetch_pc;
  retire_t         trace;

  logic [31:0] prog [prog_len];
  integer      seed;
  int          cycle_count;
  logic        timed_out;
  logic        done;
  int          mismatch_count;
  int          failure_count;

  rv_pipeline dut_i (
    .clk      (clk),
    .rst      (rst),
    .insn_in  (insn_in),
    .fetch_pc (fetch_pc),
    .trace    (trace)
  );

  rv_pipeline_checker #(.prog_len(prog_len)) checker_i (
    .clk            (clk),
    .rst            (rst),
    .trace          (trace),
    .prog           (prog),
    .done           (done),
    .mismatch_count (mismatch_count),
    .failure_count  (failure_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  // words past the program read as zero and are only ever fetched behind a jump
  function automatic logic [31:0] read_word(input logic [xlen-1:0] addr);
    if (addr >= xlen'(4 * prog_len)) begin
      return 32'd0;
    end
    return prog[addr[idx_w+1:2]];
  endfunction

  // registers x0..x7 only and control flow that always jumps forward
  task automatic build_program();
    int          kind;
    int          span;
    int          skip;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] w;
    for (int i = 0; i < prog_len - 1; i++) begin
      rd = 5'(rand_below(8));
      rs1 = 5'(rand_below(8));
      rs2 = 5'(rand_below(8));
      f3 = 3'(rand_below(8));
      w = $random(seed);
      span = (prog_len - 1 - i < 4) ? prog_len - 1 - i : 4;
      skip = 1 + rand_below(span);
      kind = rand_below(16);
      case (kind)
        0: prog[i] = enc_u(w[19:0], rd, op_lui);
        1: prog[i] = enc_u(w[19:0], rd, op_auipc);
        2, 3, 4, 5, 6: begin
          if (f3 == 3'd1) begin
            prog[i] = enc_i({7'd0, w[4:0]}, rs1, f3, rd, op_imm);
          end else if (f3 == 3'd5) begin
            f7 = w[31] ? funct7_alt : 7'd0;
            prog[i] = enc_i({f7, w[4:0]}, rs1, f3, rd, op_imm);
          end else begin
            prog[i] = enc_i(w[11:0], rs1, f3, rd, op_imm);
          end
        end
        7, 8, 9, 10, 11: begin
          f7 = ((f3 == 3'd0 || f3 == 3'd5) && w[0]) ? funct7_alt : 7'd0;
          prog[i] = enc_r(f7, rs2, rs1, f3, rd);
        end
        12, 13: begin
          // maps 0..5 onto beq, bne, blt, bge, bltu, bgeu
          f3 = 3'(rand_below(6));
          if (f3 >= 3'd2) begin
            f3 = f3 + 3'd2;
          end
          prog[i] = enc_b(13'(4 * skip), rs2, rs1, f3);
        end
        14: prog[i] = enc_j(21'(4 * skip), rd);
        default: prog[i] = enc_i(12'(4 * (i + skip)), 5'd0, 3'd0, rd, op_jalr);
      endcase
    end
    prog[prog_len-1] = enc_j(21'd0, 5'd0);
  endtask

  // instruction memory answering one cycle after the address
  always @(posedge clk) begin
    insn_in <= read_word(fetch_pc);
  end

  initial begin
    seed = 1868;
    rst = 1'b1;
    insn_in = 32'd0;
    cycle_count = 0;
    build_program();
    repeat (reset_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    rst <= 1'b0;
    while (!done && cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    timed_out = !done;
    if (timed_out) begin
      $display("timeout: final self-loop not reached within %0d cycles", max_cycles);
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (!timed_out && mismatch_count == 0 && failure_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: dv/rv_pipeline_checker.sv
`timescale 1ns/100ps

module rv_pipeline_checker import rv_pkg::*; #(
  parameter int prog_len = 200
) (
  input  logic        clk,
  input  logic        rst,
  input  retire_t     trace,
  input  logic [31:0] prog [prog_len],
  output logic        done,
  output int          mismatch_count,
  output int          failure_count
);

  localparam int idx_w = $clog2(prog_len);

  logic [xlen-1:0] model_regs [32];
  logic [xlen-1:0] model_pc;
  int              post_edges;
  int              bubbles_due;
  logic            seen_edge;
  logic            first_seen;

  initial begin
    done = 1'b0;
    mismatch_count = 0;
    failure_count = 0;
    model_pc = '0;
    post_edges = 0;
    bubbles_due = 0;
    seen_edge = 1'b0;
    first_seen = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
  end

  // counts edges on which the pipeline ran out of reset
  always @(posedge clk) begin
    seen_edge <= 1'b1;
    if (!rst) begin
      post_edges <= post_edges + 1;
    end
  end

  // architectural result and next pc of one instruction at model_pc
  task automatic exec_model(input logic [31:0] insn, output logic [xlen-1:0] result,
                            output logic [xlen-1:0] next_pc, output logic taken);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] src2;
    logic [4:0]      sh;
    logic            cond;
    a = model_regs[insn[19:15]];
    b = model_regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_u = {insn[31:12], 12'd0};
    imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    src2 = (insn[6:0] == op_imm) ? imm_i : b;
    sh = src2[4:0];
    result = '0;
    next_pc = model_pc + 4;
    taken = 1'b0;
    cond = 1'b0;
    case (insn[6:0])
      op_lui: result = imm_u;
      op_auipc: result = model_pc + imm_u;
      op_jal: begin
        result = model_pc + 4;
        next_pc = model_pc + imm_j;
        taken = 1'b1;
      end
      op_jalr: begin
        result = model_pc + 4;
        next_pc = (a + imm_i) & ~32'd1;
        taken = 1'b1;
      end
      op_branch: begin
        case (insn[14:12])
          3'd0: cond = a == b;
          3'd1: cond = a != b;
          3'd4: cond = $signed(a) < $signed(b);
          3'd5: cond = $signed(a) >= $signed(b);
          3'd6: cond = a < b;
          3'd7: cond = a >= b;
          default: cond = 1'b0;
        endcase
        if (cond) begin
          next_pc = model_pc + imm_b;
          taken = 1'b1;
        end
      end
      op_imm, op_reg: begin
        case (insn[14:12])
          3'd0: result = (insn[6:0] == op_reg && insn[30]) ? a - src2 : a + src2;
          3'd1: result = a << sh;
          3'd2: result = ($signed(a) < $signed(src2)) ? 32'd1 : 32'd0;
          3'd3: result = (a < src2) ? 32'd1 : 32'd0;
          3'd4: result = a ^ src2;
          3'd5: begin
            if (insn[30]) begin
              result = $signed(a) >>> sh;
            end else begin
              result = a >> sh;
            end
          end
          3'd6: result = a | src2;
          default: result = a & src2;
        endcase
      end
      default: result = '0;
    endcase
  endtask

  task automatic check_retire();
    logic [31:0]     exp_insn;
    logic [xlen-1:0] exp_result;
    logic [xlen-1:0] next_pc;
    logic            taken;
    if (!first_seen && post_edges != 4) begin
      failure_count++;
      $display("error at %0t: first instruction retired %0d cycles after reset, not 4",
               $time, post_edges);
    end
    first_seen = 1'b1;
    if (bubbles_due != 0) begin
      failure_count++;
      $display("error at %0t: instruction retired while %0d squash bubbles were still due",
               $time, bubbles_due);
    end
    bubbles_due = 0;
    exp_insn = (model_pc < xlen'(4 * prog_len)) ? prog[model_pc[idx_w+1:2]] : 32'd0;
    if (trace.pc != model_pc || trace.insn != exp_insn) begin
      mismatch_count++;
      $display("MISMATCH at %0t: retired pc %h insn %h, expected pc %h insn %h",
               $time, trace.pc, trace.insn, model_pc, exp_insn);
    end
    exec_model(exp_insn, exp_result, next_pc, taken);
    if (exp_insn[6:0] != op_branch) begin
      if (trace.result != exp_result) begin
        mismatch_count++;
        $display("MISMATCH at %0t: pc %h result %h, expected %h",
                 $time, model_pc, trace.result, exp_result);
      end
      if (exp_insn[11:7] != 5'd0) begin
        model_regs[exp_insn[11:7]] = exp_result;
      end
    end
    if (taken) begin
      bubbles_due = 2;
    end
    // the closing jal targets itself
    if (next_pc == model_pc) begin
      done = 1'b1;
    end
    model_pc = next_pc;
  endtask

  // the trace is sampled mid-cycle
  always @(negedge clk) begin
    if (seen_edge && !done) begin
      if (trace.status == cycle_no_stall) begin
        check_retire();
      end else if (!first_seen) begin
        if (trace.status != cycle_reset || trace.pc != '0 || trace.insn != '0 ||
            trace.result != '0) begin
          mismatch_count++;
          $display("MISMATCH at %0t: slot before the first retirement is not a zeroed reset",
                   $time);
        end
      end else if (trace.status == cycle_taken_branch && bubbles_due > 0) begin
        bubbles_due--;
      end else begin
        failure_count++;
        $display("error at %0t: unexpected %s slot on the trace", $time, trace.status.name());
      end
    end
  end

endmodule

// File: logic/rv_pipeline.sv
`timescale 1ns/100ps

module rv_pipeline import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [31:0]     insn_in,
  output logic [xlen-1:0] fetch_pc,
  output retire_t         trace
);

  decode_t              dec;
  logic                 redirect;
  logic [xlen-1:0]      target;
  logic [reg_idx_w-1:0] rs1_idx;
  logic [reg_idx_w-1:0] rs2_idx;
  logic [xlen-1:0]      rs1_data;
  logic [xlen-1:0]      rs2_data;
  retire_t              wb;

  // register file is read with the decode slot's source fields
  assign rs1_idx = rs1_of(dec.insn);
  assign rs2_idx = rs2_of(dec.insn);

  fetch_unit fetch_i (
    .clk      (clk),
    .rst      (rst),
    .redirect (redirect),
    .target   (target),
    .insn_in  (insn_in),
    .fetch_pc (fetch_pc),
    .dec      (dec)
  );

  reg_file rf_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1_idx),
    .rs2      (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  exec_pipe exec_i (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .redirect (redirect),
    .target   (target),
    .wb       (wb)
  );

  assign trace = wb;

endmodule

// File: logic/exec_pipe.sv
`timescale 1ns/100ps

module exec_pipe import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  decode_t         dec,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic            redirect,
  output logic [xlen-1:0] target,
  output retire_t         wb
);

  exec_t   ex;
  retire_t mem_st;

  logic [reg_idx_w-1:0] ex_rs1;
  logic [reg_idx_w-1:0] ex_rs2;
  logic [reg_idx_w-1:0] mem_rd;
  logic [reg_idx_w-1:0] wb_rd;
  logic                 mem_fwd;
  logic                 wb_fwd;
  logic [xlen-1:0]      op_a;
  logic [xlen-1:0]      op_b;

  logic [xlen-1:0] alu_result;
  logic            br_taken;
  logic [xlen-1:0] br_target;
  logic [xlen-1:0] br_link;
  logic [xlen-1:0] ex_result;
  logic [6:0]      ex_opcode;

  assign ex_rs1 = rs1_of(ex.insn);
  assign ex_rs2 = rs2_of(ex.insn);
  assign mem_rd = rd_of(mem_st.insn);
  assign wb_rd  = rd_of(wb.insn);

  // only real instructions that write a nonzero rd may forward
  assign mem_fwd = mem_st.status == cycle_no_stall && writes_rd(mem_st.insn) && mem_rd != '0;
  assign wb_fwd  = wb.status == cycle_no_stall && writes_rd(wb.insn) && wb_rd != '0;

  // the younger producer in memory wins over writeback
  assign op_a = (mem_fwd && mem_rd == ex_rs1) ? mem_st.result :
                (wb_fwd && wb_rd == ex_rs1) ? wb.result : ex.rs1_val;
  assign op_b = (mem_fwd && mem_rd == ex_rs2) ? mem_st.result :
                (wb_fwd && wb_rd == ex_rs2) ? wb.result : ex.rs2_val;

  int_alu alu_i (
    .insn   (ex.insn),
    .pc     (ex.pc),
    .a      (op_a),
    .b      (op_b),
    .result (alu_result)
  );

  branch_unit br_i (
    .insn   (ex.insn),
    .pc     (ex.pc),
    .a      (op_a),
    .b      (op_b),
    .taken  (br_taken),
    .target (br_target),
    .link   (br_link)
  );

  // jumps write the return address
  assign ex_opcode = ex.insn[6:0];
  assign ex_result = (ex_opcode == op_jal || ex_opcode == op_jalr) ? br_link : alu_result;

  assign redirect = ex.status == cycle_no_stall && br_taken;
  assign target   = br_target;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex <= '{pc: '0, insn: '0, rs1_val: '0, rs2_val: '0, status: cycle_reset};
      mem_st <= '{pc: '0, insn: '0, result: '0, status: cycle_reset};
      wb <= '{pc: '0, insn: '0, result: '0, status: cycle_reset};
    end else begin
      if (redirect) begin
        // the instruction behind the jump is squashed
        ex <= '{pc: '0, insn: '0, rs1_val: '0, rs2_val: '0, status: cycle_taken_branch};
      end else begin
        ex <= '{
          pc: dec.pc,
          insn: dec.insn,
          rs1_val: rs1_data,
          rs2_val: rs2_data,
          status: dec.status
        };
      end
      mem_st <= '{pc: ex.pc, insn: ex.insn, result: ex_result, status: ex.status};
      wb <= mem_st;
    end
  end

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/100ps

module branch_unit import rv_pkg::*; (
  input  logic [31:0]     insn,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic            taken,
  output logic [xlen-1:0] target,
  output logic [xlen-1:0] link
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] jalr_sum;
  logic            cond;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign imm_b  = {{(xlen-12){insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j  = {{(xlen-20){insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_i  = {{(xlen-12){insn[31]}}, insn[31:20]};
  assign jalr_sum = a + imm_i;

  always_comb begin
    case (funct3)
      3'b000:  cond = a == b;
      3'b001:  cond = a != b;
      3'b100:  cond = $signed(a) < $signed(b);
      3'b101:  cond = $signed(a) >= $signed(b);
      3'b110:  cond = a < b;
      3'b111:  cond = a >= b;
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    taken  = 1'b0;
    target = pc + imm_b;
    case (opcode)
      op_branch: taken = cond;
      op_jal: begin
        taken  = 1'b1;
        target = pc + imm_j;
      end
      op_jalr: begin
        taken  = 1'b1;
        // jalr target always has bit 0 cleared
        target = {jalr_sum[xlen-1:1], 1'b0};
      end
      default: taken = 1'b0;
    endcase
  end

  assign link = pc + 'd4;

endmodule

// File: logic/int_alu.sv
`timescale 1ns/100ps

module int_alu import rv_pkg::*; (
  input  logic [31:0]     insn,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic            is_imm;
  logic            alt;
  logic [xlen-1:0] op2;
  logic [4:0]      shamt;
  logic [xlen-1:0] alu_out;
  logic            f7_ok;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign imm_i  = {{(xlen-12){insn[31]}}, insn[31:20]};
  assign imm_u  = {insn[31:12], 12'd0};

  // register-immediate forms take the I immediate as second operand
  assign is_imm = opcode == op_imm;
  assign alt    = funct7 == funct7_alt;
  assign op2    = is_imm ? imm_i : b;
  assign shamt  = op2[4:0];

  always_comb begin
    alu_out = '0;
    case (funct3)
      3'b000: alu_out = (!is_imm && alt) ? a - op2 : a + op2;
      3'b001: alu_out = a << shamt;
      3'b010: alu_out = {{(xlen-1){1'b0}}, $signed(a) < $signed(op2)};
      3'b011: alu_out = {{(xlen-1){1'b0}}, a < op2};
      3'b100: alu_out = a ^ op2;
      3'b101: begin
        if (alt) begin
          alu_out = $signed(a) >>> shamt;
        end else begin
          alu_out = a >> shamt;
        end
      end
      3'b110: alu_out = a | op2;
      3'b111: alu_out = a & op2;
      default: alu_out = '0;
    endcase
  end

  // funct7 only matters for shifts on the immediate side
  always_comb begin
    if (is_imm) begin
      f7_ok = (funct3 == 3'b001) ? funct7 == 7'd0 :
              (funct3 == 3'b101) ? (funct7 == 7'd0 || alt) : 1'b1;
    end else begin
      f7_ok = funct7 == 7'd0 || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
    end
  end

  always_comb begin
    case (opcode)
      op_lui:         result = imm_u;
      op_auipc:       result = pc + imm_u;
      op_imm, op_reg: result = f7_ok ? alu_out : '0;
      default:        result = '0;
    endcase
  end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [reg_idx_w-1:0] rs1,
  input  logic [reg_idx_w-1:0] rs2,
  output logic [xlen-1:0]      rs1_data,
  output logic [xlen-1:0]      rs2_data,
  input  retire_t              wb
);

  // x0 has no storage
  logic [xlen-1:0] regs [1:2**reg_idx_w-1];

  logic                 we;
  logic [reg_idx_w-1:0] wr_idx;

  assign wr_idx = rd_of(wb.insn);
  assign we = wb.status == cycle_no_stall && writes_rd(wb.insn) && wr_idx != '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 2**reg_idx_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_idx] <= wb.result;
    end
  end

  // a write in the same cycle is passed straight to the reader
  assign rs1_data = (rs1 == '0) ? '0 :
                    (we && wr_idx == rs1) ? wb.result : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (we && wr_idx == rs2) ? wb.result : regs[rs2];

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            redirect,
  input  logic [xlen-1:0] target,
  input  logic [31:0]     insn_in,
  output logic [xlen-1:0] fetch_pc,
  output decode_t         dec
);

  // address of the word currently on insn_in
  logic [xlen-1:0] pc;

  always_comb begin
    if (rst) begin
      fetch_pc = '0;
    end else if (redirect) begin
      fetch_pc = target;
    end else begin
      fetch_pc = pc + 'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= fetch_pc;
    end
  end

  // the decode register squashes the fetched word when execute redirects
  always_ff @(posedge clk) begin
    if (rst) begin
      dec <= '{pc: '0, insn: '0, status: cycle_reset};
    end else if (redirect) begin
      dec <= '{pc: '0, insn: '0, status: cycle_taken_branch};
    end else begin
      dec <= '{pc: pc, insn: insn_in, status: cycle_no_stall};
    end
  end

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

  // register and pc width
  localparam int xlen = 32;
  localparam int reg_idx_w = 5;

  // major opcodes of the supported instructions
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  // selects sub and sra/srai
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // one-hot status of the writeback slot with invalid as all zero
  typedef enum logic [31:0] {
    cycle_invalid      = 32'd0,
    cycle_reset        = 32'd1,
    cycle_no_stall     = 32'd2,
    cycle_taken_branch = 32'd4
  } cycle_status_e;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     insn;
    cycle_status_e   status;
  } decode_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     insn;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    cycle_status_e   status;
  } exec_t;

  // shared by memory, writeback and the trace port
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     insn;
    logic [xlen-1:0] result;
    cycle_status_e   status;
  } retire_t;

  function automatic logic [reg_idx_w-1:0] rd_of(input logic [31:0] insn);
    return insn[11:7];
  endfunction

  function automatic logic [reg_idx_w-1:0] rs1_of(input logic [31:0] insn);
    return insn[19:15];
  endfunction

  function automatic logic [reg_idx_w-1:0] rs2_of(input logic [31:0] insn);
    return insn[24:20];
  endfunction

  // branches and unknown opcodes leave the register file alone
  function automatic logic writes_rd(input logic [31:0] insn);
    logic [6:0] op;
    op = insn[6:0];
    return op == op_lui || op == op_auipc || op == op_jal || op == op_jalr ||
           op == op_imm || op == op_reg;
  endfunction

endpackage
